// ==== filelist.f ====
+incdir+hw
hw/pc_sysboard_pkg.sv
hw/pc_io_decoder.sv
hw/sys_ctrl_regs.sv
hw/speaker_tone.sv
hw/nmi_logic.sv
hw/pc_sysboard.sv
verif/pc_sysboard_tb.sv

// ==== Bender.yml ====
package:
  name: pc_sysboard

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/pc_sysboard_pkg.sv
      - hw/pc_io_decoder.sv
      - hw/sys_ctrl_regs.sv
      - hw/speaker_tone.sv
      - hw/nmi_logic.sv
      - hw/pc_sysboard.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/pc_sysboard_tb.sv

// ==== verif/pc_sysboard_tb.sv ====
`include "pc_sysboard_cfg.svh"

module pc_sysboard_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import pc_sysboard_pkg::*;

   // one full tone period and its high part, counted in clk cycles
   localparam int TONE_PERIOD = 2 * (`PC_TONE_RELOAD + 1);
   localparam int TONE_HIGH   = 2 * (`PC_TONE_RELOAD - `PC_TONE_THRESH + 1);
   localparam int N_RAND      = 24;

   typedef enum {IO_CS, IO_RD, MEM, PAGE, NMI, SPK} kind_e;

   // addr: io/mem address, dma channel (PAGE) or window length (SPK)
   // strb: {rd,wr} for io, {memr,memw} for mem, {parity err,chan check} for NMI
   typedef struct {
      string       name;
      kind_e       kind;
      logic [19:0] addr;
      logic [7:0]  wdata;
      logic [1:0]  strb;
      logic [11:0] exp;
   } entry_t;

   logic                      clk;
   logic                      reset_n;
   io_bus_t                   io_bus;
   mem_bus_t                  mem_bus;
   logic [1:0]                dma_ch;
   logic                      parity_err_n;
   logic                      io_ch_ck_n;
   io_sel_t                   ext_cs;
   mem_sel_t                  mem_sel;
   logic [`PC_DATA_W-1:0]     rdata;
   logic                      rd_valid;
   logic [`PC_DMA_PAGE_W-1:0] dma_page;
   logic                      nmi;
   logic                      speaker;

   entry_t      tests_q[$];
   logic [31:0] lfsr = 32'h238b_d456;
   int          cycles = 0;
   int          limit;
   int          errors = 0;
   int          passed = 0;
   int          failed = 0;
   logic        test_ok;

   pc_sysboard dut_i (
      .clk            (clk),
      .reset_n        (reset_n),
      .io_bus_i       (io_bus),
      .mem_bus_i      (mem_bus),
      .dma_ch_i       (dma_ch),
      .parity_err_n_i (parity_err_n),
      .io_ch_ck_n_i   (io_ch_ck_n),
      .ext_cs_o       (ext_cs),
      .mem_sel_o      (mem_sel),
      .rdata_o        (rdata),
      .rd_valid_o     (rd_valid),
      .dma_page_o     (dma_page),
      .nmi_o          (nmi),
      .speaker_o      (speaker)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("timeout: tests still running after %0d cycles", cycles);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   // x^32 + x^22 + x^2 + x + 1, one shift per bit handed out
   function automatic logic [31:0] take_bits(int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   // 32 ports per block, six blocks from 0x000, only during rd or wr
   function automatic io_sel_t expect_cs(logic [9:0] a, logic rd, logic wr);
      io_sel_t s;
      s = '0;
      if ((rd || wr) && a < 10'h0C0) begin
         s = io_sel_t'(6'b100000 >> (a / 32));
      end
      return s;
   endfunction

   function automatic void add_test(string name, kind_e kind, logic [19:0] addr,
                                    logic [7:0] wdata, logic [1:0] strb, logic [11:0] exp);
      entry_t e;
      e.name  = name;
      e.kind  = kind;
      e.addr  = addr;
      e.wdata = wdata;
      e.strb  = strb;
      e.exp   = exp;
      tests_q.push_back(e);
   endfunction

   task automatic check_cs(string name, io_sel_t exp, io_sel_t act);
      if (act !== exp) begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         errors++;
         test_ok = 1'b0;
      end
   endtask

   task automatic check_mem(string name, mem_sel_t exp, mem_sel_t act);
      if (act !== exp) begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         errors++;
         test_ok = 1'b0;
      end
   endtask

   task automatic check_byte(string name, logic [`PC_DATA_W-1:0] exp,
                             logic [`PC_DATA_W-1:0] act);
      if (act !== exp) begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         errors++;
         test_ok = 1'b0;
      end
   endtask

   task automatic check_page(string name, logic [`PC_DMA_PAGE_W-1:0] exp,
                             logic [`PC_DMA_PAGE_W-1:0] act);
      if (act !== exp) begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         errors++;
         test_ok = 1'b0;
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
         errors++;
         test_ok = 1'b0;
      end
   endtask

   task automatic check_count(string name, int exp, int act);
      if (act != exp) begin
         $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
         errors++;
         test_ok = 1'b0;
      end
   endtask

   task automatic end_test(string name);
      $display("%-18s %s", name, test_ok ? "ok" : "mismatch");
      if (test_ok) passed++;
      else failed++;
   endtask

   // strobe for one cycle, then one idle cycle carrying the read result
   task automatic io_cycle(input io_bus_t bus, output io_sel_t cs,
                           output logic [7:0] rd_data, output logic v_now,
                           output logic v_after);
      @(posedge clk);
      io_bus <= bus;
      @(negedge clk);
      cs    = ext_cs;
      v_now = rd_valid;
      @(posedge clk);
      io_bus <= '0;
      @(negedge clk);
      rd_data = rdata;
      v_after = rd_valid;
   endtask

   task automatic run_entry(entry_t e);
      io_bus_t    bus;
      mem_bus_t   mb;
      io_sel_t    cs;
      logic [7:0] rd_data;
      logic       v_now;
      logic       v_after;
      int         high;
      test_ok = 1'b1;
      case (e.kind)
         IO_CS, IO_RD: begin
            bus.addr  = e.addr[9:0];
            bus.wdata = e.wdata;
            bus.rd    = e.strb[1];
            bus.wr    = e.strb[0];
            io_cycle(bus, cs, rd_data, v_now, v_after);
            if (e.kind == IO_CS) begin
               check_cs(e.name, io_sel_t'(e.exp[5:0]), cs);
            end else begin
               check_byte(e.name, e.exp[7:0], rd_data);
               check_bit({e.name, "/valid_early"}, 1'b0, v_now);
               check_bit({e.name, "/valid"}, 1'b1, v_after);
            end
         end
         MEM: begin
            mb.addr = e.addr;
            mb.memr = e.strb[1];
            mb.memw = e.strb[0];
            @(posedge clk);
            mem_bus <= mb;
            @(negedge clk);
            check_mem(e.name, mem_sel_t'(e.exp), mem_sel);
            @(posedge clk);
            mem_bus <= '0;
         end
         PAGE: begin
            @(posedge clk);
            dma_ch <= e.addr[1:0];
            @(negedge clk);
            check_page(e.name, e.exp[3:0], dma_page);
         end
         NMI: begin
            @(posedge clk);
            parity_err_n <= ~e.strb[1];
            io_ch_ck_n   <= ~e.strb[0];
            @(posedge clk);
            parity_err_n <= 1'b1;
            io_ch_ck_n   <= 1'b1;
            @(negedge clk);
            check_bit(e.name, e.exp[0], nmi);
         end
         SPK: begin
            high = 0;
            repeat (int'(e.addr)) begin
               @(negedge clk);
               if (speaker) high++;
            end
            check_count(e.name, int'(e.exp), high);
         end
         default: ;
      endcase
      end_test(e.name);
   endtask

   task automatic build_table();
      // io decode, writes only to blocks outside the board registers
      add_test("dec_dma_rd",   IO_CS, 20'h000, 8'h00, 2'b10, 12'h020);
      add_test("dec_pic_wr",   IO_CS, 20'h021, 8'h5A, 2'b01, 12'h010);
      add_test("dec_pit_rd",   IO_CS, 20'h043, 8'h00, 2'b10, 12'h008);
      add_test("dec_ppi_rd",   IO_CS, 20'h062, 8'h00, 2'b10, 12'h004);
      add_test("dec_page_rd",  IO_CS, 20'h083, 8'h00, 2'b10, 12'h002);
      add_test("dec_nmi_rd",   IO_CS, 20'h0A0, 8'h00, 2'b10, 12'h001);
      add_test("dec_idle",     IO_CS, 20'h040, 8'h00, 2'b00, 12'h000);
      add_test("dec_unused",   IO_CS, 20'h0C0, 8'h00, 2'b10, 12'h000);
      add_test("dec_a9",       IO_CS, 20'h220, 8'h00, 2'b10, 12'h000);
      add_test("dec_a8",       IO_CS, 20'h121, 8'hFF, 2'b01, 12'h000);
      // memory, rom sockets on bits 11..4, ram banks on 3..0
      add_test("rom_f0000",    MEM, 20'hF0000, 8'h00, 2'b10, 12'h010);
      add_test("rom_f2000",    MEM, 20'hF2000, 8'h00, 2'b10, 12'h020);
      add_test("rom_fe000",    MEM, 20'hFE000, 8'h00, 2'b10, 12'h800);
      add_test("rom_write",    MEM, 20'hFE000, 8'h00, 2'b01, 12'h000);
      add_test("ram_bank0",    MEM, 20'h01234, 8'h00, 2'b10, 12'h001);
      add_test("ram_bank2",    MEM, 20'h20000, 8'h00, 2'b10, 12'h004);
      add_test("ram_bank3_wr", MEM, 20'h3FFFF, 8'h00, 2'b01, 12'h008);
      add_test("mem_80000",    MEM, 20'h80000, 8'h00, 2'b10, 12'h000);
      add_test("mem_e0000",    MEM, 20'hE0000, 8'h00, 2'b10, 12'h000);
      add_test("mem_idle",     MEM, 20'h10000, 8'h00, 2'b00, 12'h000);
      // control port, gate stays off so port c sees tone high
      add_test("wr_port_b",    IO_CS, 20'h061, 8'h86, 2'b01, 12'h004);
      add_test("rd_port_b",    IO_RD, 20'h061, 8'h00, 2'b10, 12'h086);
      add_test("rd_port_a_sw", IO_RD, 20'h060, 8'h00, 2'b10, `PC_SW1_CONFIG);
      add_test("rd_port_c_lo", IO_RD, 20'h062, 8'h00, 2'b10, {4'b0010, `PC_SW2_LO});
      add_test("wr_port_b_0",  IO_CS, 20'h061, 8'h00, 2'b01, 12'h004);
      add_test("rd_port_a_kb", IO_RD, 20'h060, 8'h00, 2'b10, 12'h000);
      add_test("rd_port_c_hi", IO_RD, 20'h062, 8'h00, 2'b10, {4'b0010, `PC_SW2_HI});
      add_test("rd_other",     IO_RD, 20'h040, 8'h00, 2'b10, 12'h000);
      // dma page file, upper data nibble ignored
      add_test("wr_page0",     IO_CS, 20'h080, 8'h03, 2'b01, 12'h002);
      add_test("wr_page1",     IO_CS, 20'h081, 8'hA5, 2'b01, 12'h002);
      add_test("wr_page2",     IO_CS, 20'h082, 8'h0C, 2'b01, 12'h002);
      add_test("wr_page3",     IO_CS, 20'h083, 8'hF9, 2'b01, 12'h002);
      add_test("page_ch0",     PAGE, 20'h0, 8'h00, 2'b00, 12'h003);
      add_test("page_ch1",     PAGE, 20'h1, 8'h00, 2'b00, 12'h005);
      add_test("page_ch2",     PAGE, 20'h2, 8'h00, 2'b00, 12'h00C);
      add_test("page_ch3",     PAGE, 20'h3, 8'h00, 2'b00, 12'h009);
      // nmi path
      add_test("nmi_masked",   NMI, 20'h0, 8'h00, 2'b01, 12'h000);
      add_test("wr_b_iock_dis", IO_CS, 20'h061, 8'h20, 2'b01, 12'h004);
      add_test("wr_b_enable",  IO_CS, 20'h061, 8'h00, 2'b01, 12'h004);
      add_test("wr_nmi_mask",  IO_CS, 20'h0A0, 8'h80, 2'b01, 12'h001);
      add_test("nmi_iock",     NMI, 20'h0, 8'h00, 2'b01, 12'h001);
      add_test("rd_c_iock",    IO_RD, 20'h062, 8'h00, 2'b10, {4'b0110, `PC_SW2_HI});
      add_test("wr_b_iock_off", IO_CS, 20'h061, 8'h20, 2'b01, 12'h004);
      add_test("nmi_iock_off", NMI, 20'h0, 8'h00, 2'b00, 12'h000);
      add_test("rd_c_iock_off", IO_RD, 20'h062, 8'h00, 2'b10, {4'b0010, `PC_SW2_HI});
      add_test("nmi_parity",   NMI, 20'h0, 8'h00, 2'b10, 12'h001);
      add_test("rd_c_parity",  IO_RD, 20'h062, 8'h00, 2'b10, {4'b1010, `PC_SW2_HI});
      add_test("wr_b_pck_off", IO_CS, 20'h061, 8'h10, 2'b01, 12'h004);
      add_test("nmi_par_off",  NMI, 20'h0, 8'h00, 2'b00, 12'h000);
      add_test("rd_c_par_off", IO_RD, 20'h062, 8'h00, 2'b10, {4'b0010, `PC_SW2_HI});
      // speaker, window length in addr
      add_test("wr_b_spk",     IO_CS, 20'h061, 8'h02, 2'b01, 12'h004);
      add_test("spk_gate_off", SPK, 20'd300, 8'h00, 2'b00, 12'd300);
      add_test("wr_b_gate_on", IO_CS, 20'h061, 8'h03, 2'b01, 12'h004);
      add_test("spk_gate_on",  SPK, TONE_PERIOD, 8'h00, 2'b00, TONE_HIGH);
      add_test("wr_b_spk_off", IO_CS, 20'h061, 8'h01, 2'b01, 12'h004);
      add_test("spk_data_off", SPK, 20'd300, 8'h00, 2'b00, 12'd0);
   endtask

   initial begin
      io_bus_t    bus;
      io_sel_t    cs;
      logic [7:0] rd_data;
      logic       v_now;
      logic       v_after;
      logic [1:0] s;
      reset_n      = 1'b0;
      io_bus       = '0;
      mem_bus      = '0;
      dma_ch       = 2'd0;
      parity_err_n = 1'b1;
      io_ch_ck_n   = 1'b1;
      build_table();
      limit = 8 + (tests_q.size() + N_RAND + 1) * 8 + 3 * TONE_PERIOD;

      repeat (8) @(posedge clk);
      reset_n <= 1'b1;
      @(negedge clk);
      test_ok = 1'b1;
      check_bit("reset_nmi", 1'b0, nmi);
      check_bit("reset_rd_valid", 1'b0, rd_valid);
      check_bit("reset_speaker", 1'b0, speaker);
      end_test("reset_state");

      foreach (tests_q[i]) begin
         run_entry(tests_q[i]);
      end

      // random decode, rd half the time, wr a quarter
      for (int r = 0; r < N_RAND; r++) begin
         test_ok   = 1'b1;
         bus.addr  = take_bits(10);
         bus.wdata = take_bits(8);
         s         = take_bits(2);
         bus.rd    = s[1];
         bus.wr    = s[0] & ~s[1];
         io_cycle(bus, cs, rd_data, v_now, v_after);
         check_cs($sformatf("rand_io_%0d", r), expect_cs(bus.addr, bus.rd, bus.wr), cs);
         end_test($sformatf("rand_io_%0d", r));
      end

      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               passed + failed, passed, failed, errors);
      if (failed == 0 && errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// ==== hw/pc_sysboard.sv ====
`include "pc_sysboard_cfg.svh"

module pc_sysboard (
   input  logic                       clk,
   input  logic                       reset_n,
   input  pc_sysboard_pkg::io_bus_t   io_bus_i,
   input  pc_sysboard_pkg::mem_bus_t  mem_bus_i,
   input  logic [1:0]                 dma_ch_i,
   input  logic                       parity_err_n_i,
   input  logic                       io_ch_ck_n_i,
   output pc_sysboard_pkg::io_sel_t   ext_cs_o,
   output pc_sysboard_pkg::mem_sel_t  mem_sel_o,
   output logic [`PC_DATA_W-1:0]      rdata_o,
   output logic                       rd_valid_o,
   output logic [`PC_DMA_PAGE_W-1:0]  dma_page_o,
   output logic                       nmi_o,
   output logic                       speaker_o
);

   import pc_sysboard_pkg::*;

   io_sel_t     io_sel;     // ungated block decode
   ctrl_port_t  ctrl_port;
   chk_status_t chk_status;
   logic        nmi_mask;
   logic        tone;       // timer 2 out, also on port c

   pc_io_decoder u_decoder (
      .io_bus_i  (io_bus_i),
      .mem_bus_i (mem_bus_i),
      .io_sel_o  (io_sel),
      .ext_cs_o  (ext_cs_o),
      .mem_sel_o (mem_sel_o)
   );

   sys_ctrl_regs u_ctrl_regs (
      .clk         (clk),
      .reset_n     (reset_n),
      .io_bus_i    (io_bus_i),
      .io_sel_i    (io_sel),
      .tone_i      (tone),
      .chk_i       (chk_status),
      .dma_ch_i    (dma_ch_i),
      .ctrl_port_o (ctrl_port),
      .nmi_mask_o  (nmi_mask),
      .dma_page_o  (dma_page_o),
      .rdata_o     (rdata_o),
      .rd_valid_o  (rd_valid_o)
   );

   speaker_tone u_tone (
      .clk       (clk),
      .reset_n   (reset_n),
      .ctrl_i    (ctrl_port),
      .tone_o    (tone),
      .speaker_o (speaker_o)
   );

   nmi_logic u_nmi (
      .clk            (clk),
      .reset_n        (reset_n),
      .ctrl_i         (ctrl_port),
      .nmi_mask_i     (nmi_mask),
      .parity_err_n_i (parity_err_n_i),
      .io_ch_ck_n_i   (io_ch_ck_n_i),
      .chk_o          (chk_status),
      .nmi_o          (nmi_o)
   );

endmodule

// ==== hw/nmi_logic.sv ====
module nmi_logic (
   input  logic                         clk,
   input  logic                         reset_n,
   input  pc_sysboard_pkg::ctrl_port_t  ctrl_i,
   input  logic                         nmi_mask_i,
   input  logic                         parity_err_n_i,
   input  logic                         io_ch_ck_n_i,
   output pc_sysboard_pkg::chk_status_t chk_o,
   output logic                         nmi_o
);

   logic [1:0] chk_set;
   logic [1:0] chk_clr;

   // bit 1 parity and bit 0 channel check as in chk_o
   assign chk_set = ~{parity_err_n_i, io_ch_ck_n_i};
   assign chk_clr = {ctrl_i.pck_dis, ctrl_i.iock_dis};

   // sticky until the matching disable bit in port b is set
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         chk_o <= '0;
      end else begin
         chk_o <= (chk_o | chk_set) & ~chk_clr; // disable wins
      end
   end

   assign nmi_o = nmi_mask_i & (chk_o.parity_chk | chk_o.io_chk);

endmodule

// ==== hw/speaker_tone.sv ====
`include "pc_sysboard_cfg.svh"

module speaker_tone (
   input  logic                        clk,
   input  logic                        reset_n,
   input  pc_sysboard_pkg::ctrl_port_t ctrl_i,
   output logic                        tone_o,
   output logic                        speaker_o
);

   logic                      half_en_q; // stands in for the divided pit clock
   logic [`PC_TONE_CNT_W-1:0] count_q;
   logic                      tone_raw;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         half_en_q <= 1'b0;
         count_q   <= `PC_TONE_RELOAD;
      end else begin
         half_en_q <= ~half_en_q;
         if (half_en_q) begin
            if (count_q == '0) begin
               count_q <= `PC_TONE_RELOAD; // wrap
            end else begin
               count_q <= count_q - 1'b1;
            end
         end
      end
   end

   // square wave from the upper part of the count
   assign tone_raw = (count_q >= `PC_TONE_THRESH);

   // out2 sits high while the gate is off
   assign tone_o    = ctrl_i.tim2_gate ? tone_raw : 1'b1;
   assign speaker_o = tone_o & ctrl_i.spk_data;

endmodule

// ==== hw/sys_ctrl_regs.sv ====
`include "pc_sysboard_cfg.svh"

module sys_ctrl_regs (
   input  logic                              clk,
   input  logic                              reset_n,
   input  pc_sysboard_pkg::io_bus_t          io_bus_i,
   input  pc_sysboard_pkg::io_sel_t          io_sel_i,
   input  logic                              tone_i,
   input  pc_sysboard_pkg::chk_status_t      chk_i,
   input  logic [1:0]                        dma_ch_i,
   output pc_sysboard_pkg::ctrl_port_t       ctrl_port_o,
   output logic                              nmi_mask_o,
   output logic [`PC_DMA_PAGE_W-1:0]         dma_page_o,
   output logic [`PC_DATA_W-1:0]             rdata_o,
   output logic                              rd_valid_o
);

   logic                      wr_port_b;
   logic                      wr_page;
   logic                      wr_nmi;
   logic [3:0]                sw2_nibble;
   logic [`PC_DATA_W-1:0]     rd_mux;
   logic [`PC_DMA_PAGE_W-1:0] page_q [4]; // one per dma channel

   // only port b is writable, a and c are inputs on the board
   assign wr_port_b = io_bus_i.wr && io_sel_i.ppi
                      && (io_bus_i.addr[1:0] == `PC_PPI_PORT_B);
   assign wr_page   = io_bus_i.wr && io_sel_i.dma_pg;
   assign wr_nmi    = io_bus_i.wr && io_sel_i.nmi_reg;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         ctrl_port_o <= '0;
         nmi_mask_o  <= 1'b0;
         for (int i = 0; i < 4; i++) begin
            page_q[i] <= '0;
         end
      end else begin
         if (wr_port_b) begin
            ctrl_port_o <= io_bus_i.wdata;
         end
         if (wr_nmi) begin
            nmi_mask_o <= io_bus_i.wdata[7]; // only d7 is latched
         end
         if (wr_page) begin
            page_q[io_bus_i.addr[1:0]] <= io_bus_i.wdata[`PC_DMA_PAGE_W-1:0];
         end
      end
   end

   // page file read side follows the active channel
   assign dma_page_o = page_q[dma_ch_i];

   // sw2 is read a nibble at a time
   assign sw2_nibble = ctrl_port_o.sw2_hi_n ? `PC_SW2_LO : `PC_SW2_HI;

   always_comb begin
      rd_mux = '0;
      if (io_sel_i.ppi) begin
         case (io_bus_i.addr[1:0])
            `PC_PPI_PORT_A: begin
               // keyboard byte not modelled, reads 0 on that path
               rd_mux = ctrl_port_o.sw1_sel ? `PC_SW1_CONFIG : '0;
            end
            `PC_PPI_PORT_B: rd_mux = ctrl_port_o;
            `PC_PPI_PORT_C: begin
               rd_mux = {chk_i.parity_chk, chk_i.io_chk, tone_i, ~tone_i, sw2_nibble};
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         rd_valid_o <= 1'b0;
      end else begin
         rd_valid_o <= io_bus_i.rd; // one pulse per strobe
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         rdata_o <= '0;
      end else if (io_bus_i.rd) begin
         rdata_o <= rd_mux;
      end
   end

endmodule

// ==== hw/pc_io_decoder.sv ====
`include "pc_sysboard_cfg.svh"

module pc_io_decoder (
   input  pc_sysboard_pkg::io_bus_t  io_bus_i,
   input  pc_sysboard_pkg::mem_bus_t mem_bus_i,
   output pc_sysboard_pkg::io_sel_t  io_sel_o,
   output pc_sysboard_pkg::io_sel_t  ext_cs_o,
   output pc_sysboard_pkg::mem_sel_t mem_sel_o
);

   logic io_cycle;
   logic rom_hit;
   logic ram_hit;

   // 138 style block decode with bits 9..8 as the active low enables
   always_comb begin
      io_sel_o = '0;
      if (io_bus_i.addr[9:8] == 2'b00) begin
         case (io_bus_i.addr[7:5])
            `PC_BLK_DMA:    io_sel_o.dma     = 1'b1;
            `PC_BLK_PIC:    io_sel_o.pic     = 1'b1;
            `PC_BLK_PIT:    io_sel_o.pit     = 1'b1;
            `PC_BLK_PPI:    io_sel_o.ppi     = 1'b1;
            `PC_BLK_DMA_PG: io_sel_o.dma_pg  = 1'b1;
            `PC_BLK_NMI:    io_sel_o.nmi_reg = 1'b1;
            default: ;                               // 0x0c0..0x0ff unused
         endcase
      end
   end

   assign io_cycle = io_bus_i.rd || io_bus_i.wr;
   assign ext_cs_o = io_cycle ? io_sel_o : '0;     // chips only see a live cycle

   assign rom_hit = (mem_bus_i.addr[19:16] == `PC_ROM_PAGE) && mem_bus_i.memr;
   assign ram_hit = (mem_bus_i.addr[19:18] == 2'b00) && (mem_bus_i.memr || mem_bus_i.memw);

   always_comb begin
      mem_sel_o = '0;
      if (rom_hit) begin
         mem_sel_o.rom_cs = 8'b1 << mem_bus_i.addr[15:13]; // 8k per socket
      end
      if (ram_hit) begin
         mem_sel_o.ram_bank = 4'b1 << mem_bus_i.addr[17:16];
      end
   end

   // cpu never issues both strobes in one cycle
   a_rd_wr_excl: assert final ($onehot0({io_bus_i.rd, io_bus_i.wr}))
      else $error("io rd and wr high together");

endmodule

// ==== hw/pc_sysboard_pkg.sv ====
`include "pc_sysboard_cfg.svh"

package pc_sysboard_pkg;

   // cpu side i/o cycle, strobes last one clock
   typedef struct packed {
      logic [`PC_IO_ADDR_W-1:0] addr;
      logic [`PC_DATA_W-1:0]    wdata;
      logic                     rd;
      logic                     wr;
   } io_bus_t;

   // memory cycle, memr/memw are levels
   typedef struct packed {
      logic [`PC_MEM_ADDR_W-1:0] addr;
      logic                      memr;
      logic                      memw;
   } mem_bus_t;

   // one bit per external chip or board register
   typedef struct packed {
      logic dma;
      logic pic;
      logic pit;
      logic ppi;
      logic dma_pg;
      logic nmi_reg;
   } io_sel_t;

   typedef struct packed {
      logic [7:0] rom_cs;   // one 8k rom socket each
      logic [3:0] ram_bank; // 64k banks
   } mem_sel_t;

   // port b, msb first so tim2_gate lands on bit 0
   typedef struct packed {
      logic sw1_sel;
      logic kbd_clk_low;
      logic iock_dis;
      logic pck_dis;
      logic motor_off;
      logic sw2_hi_n;
      logic spk_data;
      logic tim2_gate;
   } ctrl_port_t;

   typedef struct packed {
      logic parity_chk;
      logic io_chk;
   } chk_status_t;

endpackage

// ==== hw/pc_sysboard_cfg.svh ====
`ifndef PC_SYSBOARD_CFG_SVH
`define PC_SYSBOARD_CFG_SVH

// bus widths
`define PC_IO_ADDR_W    10
`define PC_MEM_ADDR_W   20
`define PC_DATA_W       8
`define PC_DMA_PAGE_W   4

// io blocks, value of addr bits 7..5 with bits 9..8 clear
`define PC_BLK_DMA      3'd0
`define PC_BLK_PIC      3'd1
`define PC_BLK_PIT      3'd2
`define PC_BLK_PPI      3'd3
`define PC_BLK_DMA_PG   3'd4
`define PC_BLK_NMI      3'd5

// ppi port offsets, addr bits 1..0
`define PC_PPI_PORT_A   2'd0
`define PC_PPI_PORT_B   2'd1
`define PC_PPI_PORT_C   2'd2

// board switches, open switch reads as 1
`define PC_SW1_CONFIG   8'h2C
`define PC_SW2_LO       4'h6
`define PC_SW2_HI       4'hE

`define PC_ROM_PAGE     4'hF  // top nibble of the bios window

// timer 2 tone
`define PC_TONE_CNT_W   12
`define PC_TONE_RELOAD  12'h533
`define PC_TONE_THRESH  12'h299

`endif
